// ==== ym_timer_block.f ====
+incdir+verification
rtl/ym_timer_pkg.sv
rtl/ym_host_regs.sv
rtl/ym_sample_prescaler.sv
rtl/ym_timer.sv
rtl/ym_timer_block.sv
verification/ym_timer_block_tb.sv

// ==== verification/ym_tb_tasks.svh ====
`ifndef YM_TB_TASKS_SVH
`define YM_TB_TASKS_SVH

//////////////////////////////
// apb master

// setup cycle, then access cycle.
task automatic apb_write(input logic [2:0] addr, input logic [7:0] data);
	@(posedge MCLK);
	paddr_i <= addr;
	psel_i <= 1'b1;
	penable_i <= 1'b0;
	pwrite_i <= 1'b1;
	pwdata_i <= data;
	@(posedge MCLK);
	penable_i <= 1'b1;
	@(posedge MCLK);
	psel_i <= 1'b0;
	penable_i <= 1'b0;
	pwrite_i <= 1'b0;
endtask

// read data sampled mid access cycle.
task automatic apb_read(input logic [2:0] addr, output logic [7:0] data);
	@(posedge MCLK);
	paddr_i <= addr;
	psel_i <= 1'b1;
	penable_i <= 1'b0;
	pwrite_i <= 1'b0;
	@(posedge MCLK);
	penable_i <= 1'b1;
	@(negedge MCLK);
	data = prdata_o;
	@(posedge MCLK);
	psel_i <= 1'b0;
	penable_i <= 1'b0;
endtask

// address slot, then data slot.
task automatic set_reg(input logic [7:0] addr, input logic [7:0] data);
	apb_write(3'b000, addr);
	apb_write(3'b100, data);
endtask

//////////////////////////////
// waits

// cycles counted at falling edges, -1 on timeout.
task automatic wait_for_rise(input bit sel_b, input int max_cycles, output int cycles);
	int n;
	logic flag;
	n = 0;
	flag = 1'b0;
	cycles = -1;
	while (!flag && n < max_cycles) begin
		@(negedge MCLK);
		n++;
		flag = sel_b ? timer_b_status_o : timer_a_status_o;
	end
	if (flag) begin
		cycles = n;
	end else begin
		timeout_errors++;
		$display("timeout at %0t: timer %s flag never went high within %0d cycles",
			$time, sel_b ? "B" : "A", max_cycles);
	end
endtask

`endif

// ==== verification/ym_timer_block_tb.sv ====
`timescale 1ns/1ps

module ym_timer_block_tb;

	localparam int SAMPLE_DIV = 4;
	// clocks per timer b count.
	localparam int SUB_DIV = SAMPLE_DIV * ym_timer_pkg::TIMER_B_SUBDIV;

	logic MCLK;
	logic reset_i;
	logic [2:0] paddr_i;
	logic psel_i;
	logic penable_i;
	logic pwrite_i;
	logic [7:0] pwdata_i;
	logic [7:0] prdata_o;
	logic pready_o;
	logic timer_a_status_o;
	logic timer_b_status_o;
	logic mode_ch3_o;
	logic mode_csm_o;

	int value_errors;
	int timeout_errors;
	integer seed;
	int value_a;
	int value_b;
	int cycles;
	int min_cyc;
	int max_cyc;
	logic [7:0] rd;
	logic [7:0] exp_status;

	ym_timer_block #(.SAMPLE_DIV(SAMPLE_DIV)) u_ym_timer_block
		(
		.MCLK(MCLK),
		.reset_i(reset_i),
		.paddr_i(paddr_i),
		.psel_i(psel_i),
		.penable_i(penable_i),
		.pwrite_i(pwrite_i),
		.pwdata_i(pwdata_i),
		.prdata_o(prdata_o),
		.pready_o(pready_o),
		.timer_a_status_o(timer_a_status_o),
		.timer_b_status_o(timer_b_status_o),
		.mode_ch3_o(mode_ch3_o),
		.mode_csm_o(mode_csm_o)
		);

	always #50 MCLK = ~MCLK;

	`include "ym_tb_tasks.svh"

	//////////////////////////////
	// checks

	assert property (@(posedge MCLK) pready_o === 1'b1)
	else begin
		value_errors++;
		$display("ERROR at %0t: pready_o went low", $time);
	end

	// csm mode is a case of ch3 mode.
	assert property (@(posedge MCLK) disable iff (reset_i) mode_csm_o |-> mode_ch3_o)
	else begin
		value_errors++;
		$display("ERROR at %0t: mode_csm_o high without mode_ch3_o", $time);
	end

	assert property (@(posedge MCLK) prdata_o[7:2] === 6'b0)
	else begin
		value_errors++;
		$display("ERROR at %0t: unused status bits not zero", $time);
	end

	task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		assert (actual === expected) else begin
			value_errors++;
			$display("ERROR at %0t: %s is %0h, expected %0h", $time, what, actual, expected);
		end
	endtask

	task automatic check_not_early(input int seen, input int min_cycles, input string what);
		if (seen >= 0) begin
			assert (seen >= min_cycles) else begin
				value_errors++;
				$display("ERROR at %0t: %s after %0d cycles, expected at least %0d",
					$time, what, seen, min_cycles);
			end
		end
	endtask

	task automatic stays_low(input int n_cycles);
		int n;
		for (n = 0; n < n_cycles; n++) begin
			@(negedge MCLK);
			assert (timer_a_status_o === 1'b0) else begin
				value_errors++;
				$display("ERROR at %0t: timer A flag set with its enable off", $time);
			end
		end
	endtask

	function automatic logic [7:0] ctrl_byte(input bit ld_a, input bit ld_b, input bit en_a,
		input bit en_b, input bit rst_a, input bit rst_b, input logic [1:0] mode);
		logic [7:0] b;
		b = '0;
		b[ym_timer_pkg::CTRL_LOAD_A] = ld_a;
		b[ym_timer_pkg::CTRL_LOAD_B] = ld_b;
		b[ym_timer_pkg::CTRL_FLAG_EN_A] = en_a;
		b[ym_timer_pkg::CTRL_FLAG_EN_B] = en_b;
		b[ym_timer_pkg::CTRL_RESET_A] = rst_a;
		b[ym_timer_pkg::CTRL_RESET_B] = rst_b;
		b[ym_timer_pkg::CTRL_MODE_LSB +: 2] = mode;
		return b;
	endfunction

	//////////////////////////////
	// stimulus

	initial begin
		seed = 32'h55c5_ebbb;
		value_errors = 0;
		timeout_errors = 0;
		MCLK = 1'b0;
		reset_i = 1'b1;
		paddr_i = '0;
		psel_i = 1'b0;
		penable_i = 1'b0;
		pwrite_i = 1'b0;
		pwdata_i = '0;
		repeat (16) @(posedge MCLK);
		reset_i <= 1'b0;

		// state after reset.
		@(negedge MCLK);
		check_equal(timer_a_status_o, 1'b0, "timer_a_status_o after reset");
		check_equal(timer_b_status_o, 1'b0, "timer_b_status_o after reset");
		check_equal(mode_ch3_o, 1'b0, "mode_ch3_o after reset");
		check_equal(mode_csm_o, 1'b0, "mode_csm_o after reset");
		check_equal(pready_o, 1'b1, "pready_o after reset");
		apb_read(3'b000, rd);
		check_equal(rd, 8'h00, "status from slot 0 after reset");
		apb_read(3'b100, rd);
		check_equal(rd, 8'h00, "status from slot 1 after reset");

		// timer a.
		value_a = 1016 + ($unsigned($random(seed)) % 7);
		set_reg(ym_timer_pkg::ADDR_TIMER_A_LO, value_a[7:0]);
		set_reg(ym_timer_pkg::ADDR_TIMER_A_HI, {6'b0, value_a[9:8]});
		set_reg(ym_timer_pkg::ADDR_TIMER_CTRL, ctrl_byte(1, 0, 1, 0, 0, 0, 2'b00));
		min_cyc = (1023 - value_a) * SAMPLE_DIV;
		max_cyc = (1025 - value_a) * SAMPLE_DIV + SAMPLE_DIV;
		wait_for_rise(1'b0, max_cyc, cycles);
		check_not_early(cycles, min_cyc, "timer A flag rose");
		exp_status = '0;
		exp_status[ym_timer_pkg::STATUS_A_BIT] = 1'b1;
		apb_read(3'b100, rd);
		check_equal(rd, exp_status, "status with timer A flag");

		// timer b while timer a keeps running.
		value_b = 252 + ($unsigned($random(seed)) % 3);
		set_reg(ym_timer_pkg::ADDR_TIMER_B, value_b[7:0]);
		set_reg(ym_timer_pkg::ADDR_TIMER_CTRL, ctrl_byte(1, 1, 1, 1, 0, 0, 2'b00));
		min_cyc = (255 - value_b) * SUB_DIV;
		max_cyc = (257 - value_b) * SUB_DIV + SAMPLE_DIV;
		wait_for_rise(1'b1, max_cyc, cycles);
		check_not_early(cycles, min_cyc, "timer B flag rose");
		check_equal(timer_a_status_o, 1'b1, "timer_a_status_o during timer B run");
		exp_status[ym_timer_pkg::STATUS_B_BIT] = 1'b1;
		apb_read(3'b000, rd);
		check_equal(rd, exp_status, "status with both flags");

		// clear flag a only.
		set_reg(ym_timer_pkg::ADDR_TIMER_CTRL, ctrl_byte(1, 1, 1, 1, 1, 0, 2'b00));
		@(negedge MCLK);
		check_equal(timer_a_status_o, 1'b0, "timer_a_status_o after clear");
		check_equal(timer_b_status_o, 1'b1, "timer_b_status_o after clear of A");
		max_cyc = (1025 - value_a) * SAMPLE_DIV + SAMPLE_DIV;
		wait_for_rise(1'b0, max_cyc, cycles);

		// 0x28 is not decoded.
		set_reg(8'h28, 8'hF0);
		@(negedge MCLK);
		check_equal(timer_a_status_o, 1'b1, "timer_a_status_o after write to 0x28");
		check_equal(timer_b_status_o, 1'b1, "timer_b_status_o after write to 0x28");
		check_equal(mode_ch3_o, 1'b0, "mode_ch3_o after write to 0x28");
		check_equal(mode_csm_o, 1'b0, "mode_csm_o after write to 0x28");
		apb_read(3'b100, rd);
		check_equal(rd, exp_status, "status after write to 0x28");

		// stop both timers and clear, then run A with its flag off.
		set_reg(ym_timer_pkg::ADDR_TIMER_CTRL, ctrl_byte(0, 0, 0, 0, 1, 1, 2'b00));
		@(negedge MCLK);
		check_equal(timer_a_status_o, 1'b0, "timer_a_status_o after stop");
		check_equal(timer_b_status_o, 1'b0, "timer_b_status_o after stop");
		set_reg(ym_timer_pkg::ADDR_TIMER_CTRL, ctrl_byte(1, 0, 0, 0, 0, 0, 2'b00));
		stays_low(3 * (1024 - value_a) * SAMPLE_DIV + SAMPLE_DIV);

		// mode field.
		set_reg(ym_timer_pkg::ADDR_TIMER_CTRL, ctrl_byte(0, 0, 0, 0, 0, 0, 2'b01));
		@(negedge MCLK);
		check_equal(mode_ch3_o, 1'b1, "mode_ch3_o for mode 01");
		check_equal(mode_csm_o, 1'b0, "mode_csm_o for mode 01");
		set_reg(ym_timer_pkg::ADDR_TIMER_CTRL, ctrl_byte(0, 0, 0, 0, 0, 0, 2'b10));
		@(negedge MCLK);
		check_equal(mode_ch3_o, 1'b1, "mode_ch3_o for mode 10");
		check_equal(mode_csm_o, 1'b1, "mode_csm_o for mode 10");
		set_reg(ym_timer_pkg::ADDR_TIMER_CTRL, ctrl_byte(0, 0, 0, 0, 0, 0, 2'b00));
		@(negedge MCLK);
		check_equal(mode_ch3_o, 1'b0, "mode_ch3_o for mode 00");
		check_equal(mode_csm_o, 1'b0, "mode_csm_o for mode 00");

		$display("errors: %0d value, %0d timeout", value_errors, timeout_errors);
		if (value_errors == 0 && timeout_errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

// ==== rtl/ym_timer_block.sv ====
`timescale 1ns/1ps

module ym_timer_block
	#(
	parameter int SAMPLE_DIV = 72
	)
	(
	input  logic MCLK,
	input  logic reset_i,
	input  logic [2:0] paddr_i,
	input  logic psel_i,
	input  logic penable_i,
	input  logic pwrite_i,
	input  logic [ym_timer_pkg::REG_ADDR_W-1:0] pwdata_i,
	output logic [ym_timer_pkg::REG_ADDR_W-1:0] prdata_o,
	output logic pready_o,
	output logic timer_a_status_o,
	output logic timer_b_status_o,
	output logic mode_ch3_o,
	output logic mode_csm_o
	);

	logic [ym_timer_pkg::TIMER_A_W-1:0] timer_a_val;
	logic [ym_timer_pkg::TIMER_B_W-1:0] timer_b_val;
	logic load_a;
	logic load_b;
	logic flag_en_a;
	logic flag_en_b;
	logic clr_a;
	logic clr_b;
	logic sample_tick;
	logic sub_tick;

	ym_host_regs u_host_regs
		(
		.MCLK(MCLK),
		.reset_i(reset_i),
		.paddr_i(paddr_i),
		.psel_i(psel_i),
		.penable_i(penable_i),
		.pwrite_i(pwrite_i),
		.pwdata_i(pwdata_i),
		.status_a_i(timer_a_status_o),
		.status_b_i(timer_b_status_o),
		.prdata_o(prdata_o),
		.pready_o(pready_o),
		.timer_a_val_o(timer_a_val),
		.timer_b_val_o(timer_b_val),
		.load_a_o(load_a),
		.load_b_o(load_b),
		.flag_en_a_o(flag_en_a),
		.flag_en_b_o(flag_en_b),
		.clr_a_o(clr_a),
		.clr_b_o(clr_b),
		.mode_ch3_o(mode_ch3_o),
		.mode_csm_o(mode_csm_o)
		);

	ym_sample_prescaler #(.SAMPLE_DIV(SAMPLE_DIV)) u_prescaler
		(
		.MCLK(MCLK),
		.reset_i(reset_i),
		.sample_tick_o(sample_tick),
		.sub_tick_o(sub_tick)
		);

	// timer a counts every sample.
	ym_timer #(.WIDTH(ym_timer_pkg::TIMER_A_W)) u_timer_a
		(
		.MCLK(MCLK),
		.reset_i(reset_i),
		.tick_i(sample_tick),
		.load_i(load_a),
		.value_i(timer_a_val),
		.flag_en_i(flag_en_a),
		.clr_i(clr_a),
		.status_o(timer_a_status_o)
		);

	// timer b counts every 16 samples.
	ym_timer #(.WIDTH(ym_timer_pkg::TIMER_B_W)) u_timer_b
		(
		.MCLK(MCLK),
		.reset_i(reset_i),
		.tick_i(sub_tick),
		.load_i(load_b),
		.value_i(timer_b_val),
		.flag_en_i(flag_en_b),
		.clr_i(clr_b),
		.status_o(timer_b_status_o)
		);

endmodule

// ==== rtl/ym_timer.sv ====
`timescale 1ns/1ps

module ym_timer
	#(
	parameter int WIDTH = 8
	)
	(
	input  logic MCLK,
	input  logic reset_i,
	input  logic tick_i,
	input  logic load_i,
	input  logic [WIDTH-1:0] value_i,
	input  logic flag_en_i,
	input  logic clr_i,
	output logic status_o
	);

	logic load_q;
	logic [WIDTH-1:0] cnt_q;
	logic ovf_q;
	logic status_q;

	logic load_rise;
	logic cnt_full;
	logic count_en;
	logic ovf;

	//////////////////////////////
	// load edge and overflow

	assign load_rise = load_i & ~load_q;
	assign count_en = load_i & tick_i;
	assign cnt_full = &cnt_q;

	// tick at all ones.
	assign ovf = count_en & cnt_full;

	always_ff @(posedge MCLK) begin
		if (reset_i) begin
			load_q <= 1'b0;
			ovf_q <= 1'b0;
		end else begin
			load_q <= load_i;
			ovf_q <= ovf;
		end
	end

	//////////////////////////////
	// counter

	// held at zero while stopped, like the chip.
	always_ff @(posedge MCLK) begin
		if (reset_i) begin
			cnt_q <= '0;
		end else if (!load_i) begin
			cnt_q <= '0;
		end else if (load_rise) begin
			cnt_q <= value_i;
		end else if (ovf) begin
			// reload, period is 2^WIDTH - value ticks.
			cnt_q <= value_i;
		end else if (count_en) begin
			cnt_q <= cnt_q + 1'b1;
		end
	end

	//////////////////////////////
	// status flag

	// sticky until the host clears it.
	always_ff @(posedge MCLK) begin
		if (reset_i) begin
			status_q <= 1'b0;
		end else if (clr_i) begin
			status_q <= 1'b0;
		end else if (ovf_q && flag_en_i) begin
			status_q <= 1'b1;
		end
	end

	assign status_o = status_q;

endmodule

// ==== rtl/ym_sample_prescaler.sv ====
`timescale 1ns/1ps

module ym_sample_prescaler
	#(
	parameter int SAMPLE_DIV = 72
	)
	(
	input  logic MCLK,
	input  logic reset_i,
	output logic sample_tick_o,
	output logic sub_tick_o
	);

	localparam int DIV_W = (SAMPLE_DIV > 1) ? $clog2(SAMPLE_DIV) : 1;
	localparam int SUB_W = $clog2(ym_timer_pkg::TIMER_B_SUBDIV);

	localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(SAMPLE_DIV - 1);
	localparam logic [SUB_W-1:0] SUB_LAST = SUB_W'(ym_timer_pkg::TIMER_B_SUBDIV - 1);

	logic [DIV_W-1:0] div_cnt_q;
	logic [SUB_W-1:0] sub_cnt_q;
	logic div_wrap;

	assign div_wrap = div_cnt_q == DIV_LAST;

	// mclk cycles per sample.
	always_ff @(posedge MCLK) begin
		if (reset_i) begin
			div_cnt_q <= '0;
		end else if (div_wrap) begin
			div_cnt_q <= '0;
		end else begin
			div_cnt_q <= div_cnt_q + 1'b1;
		end
	end

	// samples per timer b tick, wraps by itself.
	always_ff @(posedge MCLK) begin
		if (reset_i) begin
			sub_cnt_q <= '0;
			sample_tick_o <= 1'b0;
			sub_tick_o <= 1'b0;
		end else begin
			if (div_wrap) begin
				sub_cnt_q <= sub_cnt_q + 1'b1;
			end
			sample_tick_o <= div_wrap;
			sub_tick_o <= div_wrap & (sub_cnt_q == SUB_LAST);
		end
	end

endmodule

// ==== rtl/ym_host_regs.sv ====
`timescale 1ns/1ps

module ym_host_regs
	(
	input  logic MCLK,
	input  logic reset_i,
	input  logic [2:0] paddr_i,
	input  logic psel_i,
	input  logic penable_i,
	input  logic pwrite_i,
	input  logic [ym_timer_pkg::REG_ADDR_W-1:0] pwdata_i,
	input  logic status_a_i,
	input  logic status_b_i,
	output logic [ym_timer_pkg::REG_ADDR_W-1:0] prdata_o,
	output logic pready_o,
	output logic [ym_timer_pkg::TIMER_A_W-1:0] timer_a_val_o,
	output logic [ym_timer_pkg::TIMER_B_W-1:0] timer_b_val_o,
	output logic load_a_o,
	output logic load_b_o,
	output logic flag_en_a_o,
	output logic flag_en_b_o,
	output logic clr_a_o,
	output logic clr_b_o,
	output logic mode_ch3_o,
	output logic mode_csm_o
	);

	// top bits of timer a live in 0x25.
	localparam int A_HI_W = ym_timer_pkg::TIMER_A_W - ym_timer_pkg::REG_ADDR_W;

	logic wr_access;
	logic addr_wr;
	logic data_wr;
	logic ctrl_wr;

	logic [ym_timer_pkg::REG_ADDR_W-1:0] addr_q;

	logic [ym_timer_pkg::REG_ADDR_W-1:0] timer_a_lo_q;
	logic [A_HI_W-1:0] timer_a_hi_q;
	logic [ym_timer_pkg::TIMER_B_W-1:0] timer_b_q;

	logic load_a_q;
	logic load_b_q;
	logic flag_en_a_q;
	logic flag_en_b_q;
	logic [1:0] mode_q;

	//////////////////////////////
	// apb access decode

	// no wait states.
	assign pready_o = 1'b1;

	// transfer completes in the access phase.
	assign wr_access = psel_i & penable_i & pwrite_i;

	// paddr bit 2 picks the slot.
	assign addr_wr = wr_access & ~paddr_i[2];
	assign data_wr = wr_access & paddr_i[2];

	assign ctrl_wr = data_wr & (addr_q == ym_timer_pkg::ADDR_TIMER_CTRL);

	//////////////////////////////
	// address latch

	always_ff @(posedge MCLK) begin
		if (reset_i) begin
			addr_q <= '0;
		end else if (addr_wr) begin
			addr_q <= pwdata_i;
		end
	end

	//////////////////////////////
	// register storage

	// writes outside 0x24..0x27 fall through.
	always_ff @(posedge MCLK) begin
		if (reset_i) begin
			timer_a_lo_q <= '0;
			timer_a_hi_q <= '0;
			timer_b_q <= '0;
			load_a_q <= 1'b0;
			load_b_q <= 1'b0;
			flag_en_a_q <= 1'b0;
			flag_en_b_q <= 1'b0;
			mode_q <= 2'b00;
		end else if (data_wr) begin
			case (addr_q)
				ym_timer_pkg::ADDR_TIMER_A_LO: begin
					timer_a_lo_q <= pwdata_i;
				end
				ym_timer_pkg::ADDR_TIMER_A_HI: begin
					timer_a_hi_q <= pwdata_i[A_HI_W-1:0];
				end
				ym_timer_pkg::ADDR_TIMER_B: begin
					timer_b_q <= pwdata_i;
				end
				ym_timer_pkg::ADDR_TIMER_CTRL: begin
					load_a_q <= pwdata_i[ym_timer_pkg::CTRL_LOAD_A];
					load_b_q <= pwdata_i[ym_timer_pkg::CTRL_LOAD_B];
					flag_en_a_q <= pwdata_i[ym_timer_pkg::CTRL_FLAG_EN_A];
					flag_en_b_q <= pwdata_i[ym_timer_pkg::CTRL_FLAG_EN_B];
					mode_q <= pwdata_i[ym_timer_pkg::CTRL_MODE_LSB +: 2];
				end
				default: begin
				end
			endcase
		end
	end

	//////////////////////////////
	// outputs to the timers

	assign timer_a_val_o = {timer_a_hi_q, timer_a_lo_q};
	assign timer_b_val_o = timer_b_q;

	assign load_a_o = load_a_q;
	assign load_b_o = load_b_q;
	assign flag_en_a_o = flag_en_a_q;
	assign flag_en_b_o = flag_en_b_q;

	// reset bits are not stored, they only pulse
	// during the access cycle of the 0x27 write.
	assign clr_a_o = ctrl_wr & pwdata_i[ym_timer_pkg::CTRL_RESET_A];
	assign clr_b_o = ctrl_wr & pwdata_i[ym_timer_pkg::CTRL_RESET_B];

	//////////////////////////////
	// mode decode

	// any non-zero mode turns on ch3 special mode.
	assign mode_ch3_o = mode_q != 2'b00;
	assign mode_csm_o = mode_q == ym_timer_pkg::MODE_CSM;

	//////////////////////////////
	// status readback

	// same byte from both slots.
	always_comb begin
		prdata_o = '0;
		prdata_o[ym_timer_pkg::STATUS_A_BIT] = status_a_i;
		prdata_o[ym_timer_pkg::STATUS_B_BIT] = status_b_i;
	end

endmodule

// ==== rtl/ym_timer_pkg.sv ====
package ym_timer_pkg;

	//////////////////////////////
	// register map

	// host address and data byte width.
	localparam int REG_ADDR_W = 8;

	localparam logic [REG_ADDR_W-1:0] ADDR_TIMER_A_LO = 8'h24;
	localparam logic [REG_ADDR_W-1:0] ADDR_TIMER_A_HI = 8'h25;
	localparam logic [REG_ADDR_W-1:0] ADDR_TIMER_B    = 8'h26;
	localparam logic [REG_ADDR_W-1:0] ADDR_TIMER_CTRL = 8'h27;

	//////////////////////////////
	// fields of 0x27

	localparam int CTRL_LOAD_A    = 0;
	localparam int CTRL_LOAD_B    = 1;
	localparam int CTRL_FLAG_EN_A = 2;
	localparam int CTRL_FLAG_EN_B = 3;
	localparam int CTRL_RESET_A   = 4;
	localparam int CTRL_RESET_B   = 5;

	// two bit mode field, bits 7:6.
	localparam int CTRL_MODE_LSB = 6;

	// csm mode code.
	localparam logic [1:0] MODE_CSM = 2'b10;

	//////////////////////////////
	// timer widths

	localparam int TIMER_A_W = 10;
	localparam int TIMER_B_W = 8;

	// samples per timer b count.
	localparam int TIMER_B_SUBDIV = 16;

	//////////////////////////////
	// status byte

	localparam int STATUS_A_BIT = 0;
	localparam int STATUS_B_BIT = 1;

endpackage
